// ==== bench/csr_model.svh ====
// CSR unit reference model

csr_pkg::csr_data_t m_mtvec;
csr_pkg::csr_data_t m_mscratch;
csr_pkg::csr_data_t m_mepc;
logic [3:0]         m_mcause;
logic               m_mie;
logic               m_mpie;
logic [1:0]         m_mpp;
logic [1:0]         m_priv;
logic [63:0]        m_cycle;
logic [63:0]        m_instret;

function automatic void reset_model();
    m_mtvec    = {RESET_VEC[31:2], 2'b00};
    m_mscratch = 32'h0;
    m_mepc     = 32'h0;
    m_mcause   = 4'h0;
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_mpp      = 2'b11;
    m_priv     = 2'b11;
    m_cycle    = 64'h0;
    m_instret  = 64'h0;
endfunction

// advance the counters by one clock edge
function automatic void count_edge(input logic rst_seen, input logic retire_seen);
    if (rst_seen) begin
        reset_model();
    end else begin
        m_cycle = m_cycle + 64'd1;
        if (retire_seen) begin
            m_instret = m_instret + 64'd1;
        end
    end
endfunction

function automatic logic [31:0] mstatus_word();
    logic [31:0] w;
    w = 32'h0;
    w[priv_pkg::MIE_BIT] = m_mie;
    w[priv_pkg::MPIE_BIT] = m_mpie;
    w[priv_pkg::MPP_LO +: 2] = m_mpp;
    return w;
endfunction

// current value of an address, known is low when unmapped
function automatic void lookup(input csr_pkg::csr_addr_t a, output logic [31:0] val,
                               output logic known);
    known = 1'b1;
    case (a)
        csr_pkg::MSTATUS:  val = mstatus_word();
        csr_pkg::MISA:     val = 32'h4010_1100;
        csr_pkg::MTVEC:    val = m_mtvec;
        csr_pkg::MSCRATCH: val = m_mscratch;
        csr_pkg::MEPC:     val = m_mepc;
        csr_pkg::MCAUSE:   val = {28'h0, m_mcause};
        csr_pkg::MHARTID:  val = HART_ID;
        csr_pkg::MCYCLE,
        csr_pkg::CYCLE:    val = m_cycle[31:0];
        csr_pkg::MCYCLEH,
        csr_pkg::CYCLEH:   val = m_cycle[63:32];
        csr_pkg::MINSTRET,
        csr_pkg::INSTRET:  val = m_instret[31:0];
        csr_pkg::MINSTRETH,
        csr_pkg::INSTRETH: val = m_instret[63:32];
        default: begin
            val   = 32'h0;
            known = 1'b0;
        end
    endcase
endfunction

function automatic void apply_request(input csr_pkg::csr_addr_t a, input csr_pkg::csr_op_t o,
                                      input csr_pkg::csr_data_t w,
                                      output csr_pkg::csr_data_t rd_exp, output logic ill_exp);
    logic [31:0] old;
    logic [31:0] nv;
    logic        known;
    lookup(a, old, known);
    ill_exp = !known || (a[9:8] > m_priv) || (a[11:10] == 2'b11 && o != csr_pkg::CSR_READ);
    rd_exp  = ill_exp ? 32'h0 : old;
    if (ill_exp || o == csr_pkg::CSR_READ) begin
        return;
    end
    case (o)
        csr_pkg::CSR_RW: nv = w;
        csr_pkg::CSR_RS: nv = old | w;
        default:         nv = old & ~w;
    endcase
    case (a)
        csr_pkg::MSTATUS: begin
            m_mie  = nv[3];
            m_mpie = nv[7];
            m_mpp  = {2{nv[12]}};
        end
        csr_pkg::MTVEC:    m_mtvec = {nv[31:2], 2'b00};
        csr_pkg::MSCRATCH: m_mscratch = nv;
        csr_pkg::MEPC:     m_mepc = {nv[31:2], 2'b00};
        csr_pkg::MCAUSE:   m_mcause = nv[3:0];
        // identity and counter registers ignore writes
        default: ;
    endcase
endfunction

function automatic void apply_trap(input logic [3:0] code, input logic [31:0] pc);
    m_mepc   = {pc[31:2], 2'b00};
    m_mcause = code;
    m_mpie   = m_mie;
    m_mie    = 1'b0;
    m_mpp    = m_priv;
    m_priv   = 2'b11;
endfunction

function automatic void apply_mret();
    m_priv = m_mpp;
    m_mie  = m_mpie;
    m_mpie = 1'b1;
    m_mpp  = 2'b00;
endfunction

// ==== bench/csr_unit_tb.sv ====
// CSR unit testbench

module csr_unit_tb;

    localparam csr_pkg::csr_data_t HART_ID   = 32'h0000_0005;
    localparam csr_pkg::csr_data_t RESET_VEC = 32'h8000_0100;
    localparam int TIMEOUT = 20;

    logic               clk;
    logic               rst;
    logic               req;
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_op_t   op;
    csr_pkg::csr_data_t wdata;
    logic               accept;
    logic               ready;
    logic               done;
    csr_pkg::csr_data_t rd;
    logic               illegal;
    logic               retire;
    logic               trap_valid;
    priv_pkg::ecode_t   trap_code;
    csr_pkg::csr_data_t trap_pc;
    logic               mret;
    priv_pkg::priv_t    priv;
    csr_pkg::csr_data_t trap_vec;
    csr_pkg::csr_data_t epc;

    int errors;
    int timeouts;

    `include "csr_model.svh"

    csr_unit #(
        .HART_ID   (HART_ID),
        .RESET_VEC (RESET_VEC)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //*******************************************************************
    // clocking and reporting
    //*******************************************************************

    // one edge and a new retire value a little after it
    task automatic step();
        logic rst_seen;
        logic retire_seen;
        rst_seen = rst;
        retire_seen = retire;
        @(posedge clk);
        count_edge(rst_seen, retire_seen);
        #2;
        retire = $urandom_range(0, 1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("ERR %s got %h expected %h", name, got, exp);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!ready) begin
            timeouts++;
            $display("timeout: ready did not rise within %0d cycles", TIMEOUT);
        end
    endtask

    //*******************************************************************
    // request, trap and return
    //*******************************************************************
    task automatic csr_access(input csr_pkg::csr_addr_t a, input csr_pkg::csr_op_t o,
                              input csr_pkg::csr_data_t w);
        csr_pkg::csr_data_t exp_rd;
        logic               exp_ill;
        int                 n;
        int                 hold;
        wait_ready();
        req = 1'b1;
        addr = a;
        op = o;
        wdata = w;
        apply_request(a, o, w, exp_rd, exp_ill);
        step();
        req = 1'b0;
        n = 1;
        while (!done && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!done) begin
            timeouts++;
            $display("timeout: done did not rise for address %h", a);
            return;
        end
        if (n != 1) begin
            errors++;
            $display("done came %0d cycles after the request instead of 1", n);
        end
        if (rd !== exp_rd) mismatch("rd", rd, exp_rd);
        if (illegal !== exp_ill) mismatch("illegal", illegal, exp_ill);
        // writeback back-pressure with a write request that must be ignored
        hold = $urandom_range(0, 3);
        req = $urandom_range(0, 1);
        addr = pick_trap_reg();
        op = csr_pkg::CSR_RW;
        wdata = $urandom;
        repeat (hold) begin
            step();
            if (ready !== 1'b0) mismatch("ready", ready, 0);
            if (done !== 1'b1) mismatch("done", done, 1);
            if (rd !== exp_rd) mismatch("rd", rd, exp_rd);
            if (illegal !== exp_ill) mismatch("illegal", illegal, exp_ill);
        end
        accept = 1'b1;
        step();
        accept = 1'b0;
        req = 1'b0;
        if (ready !== 1'b1) mismatch("ready", ready, 1);
        if (done !== 1'b0) mismatch("done", done, 0);
        if (trap_vec !== m_mtvec) mismatch("trap_vec", trap_vec, m_mtvec);
    endtask

    task automatic check_trap_outputs();
        if (priv !== m_priv) mismatch("priv", priv, m_priv);
        if (epc !== m_mepc) mismatch("epc", epc, m_mepc);
        if (trap_vec !== m_mtvec) mismatch("trap_vec", trap_vec, m_mtvec);
    endtask

    task automatic take_trap(input priv_pkg::ecode_t code, input csr_pkg::csr_data_t pc);
        wait_ready();
        trap_valid = 1'b1;
        trap_code = code;
        trap_pc = pc;
        apply_trap(code, pc);
        step();
        trap_valid = 1'b0;
        check_trap_outputs();
    endtask

    task automatic machine_return();
        wait_ready();
        mret = 1'b1;
        apply_mret();
        step();
        mret = 1'b0;
        check_trap_outputs();
    endtask

    function automatic csr_pkg::csr_addr_t pick_trap_reg();
        case ($urandom_range(0, 4))
            0: return csr_pkg::MSTATUS;
            1: return csr_pkg::MTVEC;
            2: return csr_pkg::MSCRATCH;
            3: return csr_pkg::MEPC;
            default: return csr_pkg::MCAUSE;
        endcase
    endfunction

    function automatic csr_pkg::csr_addr_t pick_counter();
        case ($urandom_range(0, 7))
            0: return csr_pkg::CYCLE;
            1: return csr_pkg::CYCLEH;
            2: return csr_pkg::MCYCLE;
            3: return csr_pkg::MCYCLEH;
            4: return csr_pkg::INSTRET;
            5: return csr_pkg::INSTRETH;
            6: return csr_pkg::MINSTRET;
            default: return csr_pkg::MINSTRETH;
        endcase
    endfunction

    // 0x8ff is outside the map
    function automatic csr_pkg::csr_addr_t pick_unknown();
        csr_pkg::csr_addr_t a;
        logic [31:0]        v;
        logic               known;
        a = $urandom_range(0, 4095);
        lookup(a, v, known);
        return known ? 12'h8ff : a;
    endfunction

    //*******************************************************************
    // test sequence
    //*******************************************************************
    initial begin
        int                 i;
        csr_pkg::csr_addr_t target;
        void'($urandom(32'hf092777f));
        errors = 0;
        timeouts = 0;
        rst = 1'b1;
        req = 1'b0;
        addr = '0;
        op = csr_pkg::CSR_READ;
        wdata = '0;
        accept = 1'b0;
        retire = 1'b0;
        trap_valid = 1'b0;
        trap_code = '0;
        trap_pc = '0;
        mret = 1'b0;
        repeat (4) step();
        rst = 1'b0;

        if (ready !== 1'b1) mismatch("ready", ready, 1);
        if (done !== 1'b0) mismatch("done", done, 0);
        if (priv !== priv_pkg::PRIV_MACHINE) mismatch("priv", priv, 2'd3);
        csr_access(csr_pkg::MTVEC, csr_pkg::CSR_READ, 32'h0);
        csr_access(csr_pkg::MISA, csr_pkg::CSR_READ, 32'h0);
        csr_access(csr_pkg::MHARTID, csr_pkg::CSR_READ, 32'h0);

        // random writes with a read-back after each
        for (i = 0; i < 60; i++) begin
            target = pick_trap_reg();
            csr_access(target, csr_pkg::csr_op_t'($urandom_range(0, 3)), $urandom);
            csr_access(target, csr_pkg::CSR_READ, 32'h0);
        end

        for (i = 0; i < 16; i++) begin
            csr_access(pick_counter(), csr_pkg::CSR_READ, 32'h0);
        end

        // illegal accesses from machine mode
        for (i = 0; i < 8; i++) begin
            csr_access(pick_unknown(), csr_pkg::csr_op_t'($urandom_range(0, 3)), $urandom);
            csr_access(csr_pkg::CYCLE, csr_pkg::CSR_RW, $urandom);
            csr_access(csr_pkg::MHARTID, csr_pkg::CSR_RS, $urandom);
        end

        // trap entry and return with a drop to user mode when mpp says so
        for (i = 0; i < 12; i++) begin
            csr_access(csr_pkg::MSTATUS, csr_pkg::CSR_RW, $urandom);
            take_trap($urandom_range(0, 15), $urandom);
            csr_access(csr_pkg::MSTATUS, csr_pkg::CSR_READ, 32'h0);
            csr_access(csr_pkg::MCAUSE, csr_pkg::CSR_READ, 32'h0);
            csr_access(csr_pkg::MSTATUS, csr_pkg::CSR_RW, $urandom);
            machine_return();
            csr_access(csr_pkg::CYCLE, csr_pkg::CSR_READ, 32'h0);
            if (m_priv == priv_pkg::PRIV_USER) begin
                csr_access(pick_trap_reg(), csr_pkg::csr_op_t'($urandom_range(0, 3)), $urandom);
                csr_access(csr_pkg::MCYCLE, csr_pkg::CSR_READ, 32'h0);
                csr_access(csr_pkg::INSTRETH, csr_pkg::CSR_RS, $urandom);
                csr_access(pick_unknown(), csr_pkg::CSR_READ, 32'h0);
                take_trap($urandom_range(0, 15), $urandom);
            end
            csr_access(csr_pkg::MSTATUS, csr_pkg::CSR_READ, 32'h0);
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
+incdir+bench
hdl/csr_pkg.sv
hdl/priv_pkg.sv
hdl/csr_dec_if.sv
hdl/csr_decode.sv
hdl/csr_file.sv
hdl/csr_counters.sv
hdl/csr_result.sv
hdl/csr_unit.sv
bench/csr_unit_tb.sv

// ==== hdl/csr_counters.sv ====
// Cycle and retire counters

module csr_counters (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          retire,
    output logic [csr_pkg::COUNTER_W-1:0] cycle,
    output logic [csr_pkg::COUNTER_W-1:0] instret
);

    // free-running since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // one count per retire pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            instret <= '0;
        end else if (retire) begin
            instret <= instret + 1'b1;
        end
    end

endmodule

// ==== hdl/csr_dec_if.sv ====
// Decoded CSR request bus

interface csr_dec_if;

    logic               valid;
    csr_pkg::csr_sel_t  sel;
    csr_pkg::csr_op_t   op;
    csr_pkg::csr_data_t wdata;
    logic               write_en;
    logic               illegal;

    modport decode (
        output valid, sel, op, wdata, write_en, illegal
    );

    // register file side
    modport execute (
        input valid, sel, op, wdata, write_en
    );

    modport result (
        input valid, illegal
    );

endinterface

// ==== hdl/csr_decode.sv ====
// CSR request decode

module csr_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  logic               ready,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_op_t   op,
    input  csr_pkg::csr_data_t wdata,
    input  priv_pkg::priv_t    priv,
    csr_dec_if.decode          dec
);

    csr_pkg::csr_sel_t sel;
    logic              unknown_addr;
    logic              priv_fault;
    logic              ro_fault;

    //******************************************************************
    // address map
    //******************************************************************
    always_comb begin
        case (addr)
            csr_pkg::MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
            csr_pkg::MISA:      sel = csr_pkg::SEL_MISA;
            csr_pkg::MTVEC:     sel = csr_pkg::SEL_MTVEC;
            csr_pkg::MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
            csr_pkg::MEPC:      sel = csr_pkg::SEL_MEPC;
            csr_pkg::MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
            csr_pkg::MHARTID:   sel = csr_pkg::SEL_MHARTID;
            csr_pkg::MCYCLE,
            csr_pkg::CYCLE:     sel = csr_pkg::SEL_CYCLE_LO;
            csr_pkg::MCYCLEH,
            csr_pkg::CYCLEH:    sel = csr_pkg::SEL_CYCLE_HI;
            csr_pkg::MINSTRET,
            csr_pkg::INSTRET:   sel = csr_pkg::SEL_INSTRET_LO;
            csr_pkg::MINSTRETH,
            csr_pkg::INSTRETH:  sel = csr_pkg::SEL_INSTRET_HI;
            default:            sel = csr_pkg::SEL_NONE;
        endcase
    end

    // access checks
    assign unknown_addr = (sel == csr_pkg::SEL_NONE);
    assign priv_fault   = (addr[9:8] > priv);
    assign ro_fault     = (addr[11:10] == csr_pkg::RO_ACCESS) && (op != csr_pkg::CSR_READ);

    assign dec.valid    = req & ready;
    assign dec.sel      = sel;
    assign dec.op       = op;
    assign dec.wdata    = wdata;
    assign dec.illegal  = unknown_addr | priv_fault | ro_fault;

    // only a taken, legal, modifying request writes
    assign dec.write_en = dec.valid & ~dec.illegal & (op != csr_pkg::CSR_READ);

    // privilege compare relies on user or machine only
    a_priv_legal: assert property (
        @(posedge clk) disable iff (rst)
        (priv == priv_pkg::PRIV_USER) || (priv == priv_pkg::PRIV_MACHINE)
    );

endmodule

// ==== hdl/csr_file.sv ====
// Machine CSR register file

module csr_file #(
    parameter csr_pkg::csr_data_t HART_ID   = 32'h0000_0000,
    parameter csr_pkg::csr_data_t RESET_VEC = 32'h0000_0100
) (
    input  logic                          clk,
    input  logic                          rst,
    csr_dec_if.execute                    dec,
    input  logic [csr_pkg::COUNTER_W-1:0] cycle,
    input  logic [csr_pkg::COUNTER_W-1:0] instret,
    input  logic                          trap_valid,
    input  priv_pkg::ecode_t              trap_code,
    input  csr_pkg::csr_data_t            trap_pc,
    input  logic                          mret,
    output csr_pkg::csr_data_t            rdata,
    output priv_pkg::priv_t               priv,
    output csr_pkg::csr_data_t            trap_vec,
    output csr_pkg::csr_data_t            epc
);

    localparam int XLEN = csr_pkg::XLEN;

    csr_pkg::csr_data_t mtvec;
    csr_pkg::csr_data_t mscratch;
    csr_pkg::csr_data_t mepc;
    priv_pkg::ecode_t   mcause;
    logic               mie;
    logic               mpie;
    priv_pkg::priv_t    mpp;

    csr_pkg::csr_data_t mstatus;
    csr_pkg::csr_data_t new_val;

    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;

    // mstatus view, everything outside mie/mpie/mpp reads zero
    always_comb begin
        mstatus = '0;
        mstatus[priv_pkg::MIE_BIT]    = mie;
        mstatus[priv_pkg::MPIE_BIT]   = mpie;
        mstatus[priv_pkg::MPP_LO +: 2] = mpp;
    end

    //******************************************************************
    // read mux and modified value
    //******************************************************************
    always_comb begin
        case (dec.sel)
            csr_pkg::SEL_MSTATUS:    rdata = mstatus;
            csr_pkg::SEL_MISA:       rdata = priv_pkg::MISA_VALUE;
            csr_pkg::SEL_MTVEC:      rdata = mtvec;
            csr_pkg::SEL_MSCRATCH:   rdata = mscratch;
            csr_pkg::SEL_MEPC:       rdata = mepc;
            csr_pkg::SEL_MCAUSE:     rdata = {{(XLEN-priv_pkg::ECODE_W){1'b0}}, mcause};
            csr_pkg::SEL_MHARTID:    rdata = HART_ID;
            csr_pkg::SEL_CYCLE_LO:   rdata = cycle[XLEN-1:0];
            csr_pkg::SEL_CYCLE_HI:   rdata = cycle[csr_pkg::COUNTER_W-1:XLEN];
            csr_pkg::SEL_INSTRET_LO: rdata = instret[XLEN-1:0];
            csr_pkg::SEL_INSTRET_HI: rdata = instret[csr_pkg::COUNTER_W-1:XLEN];
            default:                 rdata = '0;
        endcase
    end

    always_comb begin
        case (dec.op)
            csr_pkg::CSR_RS: new_val = rdata | dec.wdata;
            csr_pkg::CSR_RC: new_val = rdata & ~dec.wdata;
            default:         new_val = dec.wdata;
        endcase
    end

    // misa, mhartid and counter writes fall through here
    assign wr_mstatus  = dec.write_en && (dec.sel == csr_pkg::SEL_MSTATUS);
    assign wr_mtvec    = dec.write_en && (dec.sel == csr_pkg::SEL_MTVEC);
    assign wr_mscratch = dec.write_en && (dec.sel == csr_pkg::SEL_MSCRATCH);
    assign wr_mepc     = dec.write_en && (dec.sel == csr_pkg::SEL_MEPC);
    assign wr_mcause   = dec.write_en && (dec.sel == csr_pkg::SEL_MCAUSE);

    //******************************************************************
    // status and privilege
    //******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            mie  <= 1'b0;
            mpie <= 1'b0;
            mpp  <= priv_pkg::PRIV_MACHINE;
            priv <= priv_pkg::PRIV_MACHINE;
        end else if (trap_valid) begin
            mpie <= mie;
            mie  <= 1'b0;
            mpp  <= priv;
            priv <= priv_pkg::PRIV_MACHINE;
        end else if (mret) begin
            priv <= mpp;
            mie  <= mpie;
            mpie <= 1'b1;
            mpp  <= priv_pkg::PRIV_USER;
        end else if (wr_mstatus) begin
            mie  <= new_val[priv_pkg::MIE_BIT];
            mpie <= new_val[priv_pkg::MPIE_BIT];
            // mpp holds only user or machine
            mpp  <= priv_pkg::priv_t'({2{new_val[priv_pkg::MPP_LO+1]}});
        end
    end

    // trap setup and handling registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= {RESET_VEC[XLEN-1:2], 2'b00};
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else begin
            if (wr_mtvec) begin
                mtvec <= {new_val[XLEN-1:2], 2'b00};
            end
            if (wr_mscratch) begin
                mscratch <= new_val;
            end
            if (trap_valid) begin
                mepc   <= {trap_pc[XLEN-1:2], 2'b00};
                mcause <= trap_code;
            end else begin
                if (wr_mepc) begin
                    mepc <= {new_val[XLEN-1:2], 2'b00};
                end
                if (wr_mcause) begin
                    mcause <= new_val[priv_pkg::ECODE_W-1:0];
                end
            end
        end
    end

    assign trap_vec = mtvec;
    assign epc      = mepc;

    // trap and return come from one retiring instruction
    a_trap_mret_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(trap_valid && mret)
    );

endmodule

// ==== hdl/csr_pkg.sv ====
// CSR access definitions

package csr_pkg;

    localparam int XLEN      = 32;
    localparam int COUNTER_W = 64;

    typedef logic [XLEN-1:0] csr_data_t;

    // [11:10] access bits, [9:8] minimum privilege
    typedef logic [11:0] csr_addr_t;

    // access bits value for a read-only address
    localparam logic [1:0] RO_ACCESS = 2'b11;

    typedef enum logic [1:0] {
        CSR_READ = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_t;

    //******************************************************************
    // register addresses
    //******************************************************************
    localparam csr_addr_t MSTATUS   = 12'h300;
    localparam csr_addr_t MISA      = 12'h301;
    localparam csr_addr_t MTVEC     = 12'h305;
    localparam csr_addr_t MSCRATCH  = 12'h340;
    localparam csr_addr_t MEPC      = 12'h341;
    localparam csr_addr_t MCAUSE    = 12'h342;
    localparam csr_addr_t MHARTID   = 12'hF14;
    localparam csr_addr_t MCYCLE    = 12'hB00;
    localparam csr_addr_t MCYCLEH   = 12'hB80;
    localparam csr_addr_t MINSTRET  = 12'hB02;
    localparam csr_addr_t MINSTRETH = 12'hB82;

    // user read-only shadows of the counters
    localparam csr_addr_t CYCLE     = 12'hC00;
    localparam csr_addr_t INSTRET   = 12'hC02;
    localparam csr_addr_t CYCLEH    = 12'hC80;
    localparam csr_addr_t INSTRETH  = 12'hC82;

    typedef enum logic [3:0] {
        SEL_MSTATUS,
        SEL_MISA,
        SEL_MTVEC,
        SEL_MSCRATCH,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MHARTID,
        SEL_CYCLE_LO,
        SEL_CYCLE_HI,
        SEL_INSTRET_LO,
        SEL_INSTRET_HI,
        SEL_NONE
    } csr_sel_t;

endpackage

// ==== hdl/csr_result.sv ====
// CSR result holding stage

module csr_result (
    input  logic               clk,
    input  logic               rst,
    csr_dec_if.result          dec,
    input  csr_pkg::csr_data_t rdata,
    input  logic               accept,
    output logic               ready,
    output logic               done,
    output csr_pkg::csr_data_t rd,
    output logic               illegal
);

    typedef enum logic {
        ST_IDLE,
        ST_DONE
    } state_t;

    state_t state;

    // idle until a request is taken and then wait for writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (dec.valid) state <= ST_DONE;
                ST_DONE: if (accept) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign ready = (state == ST_IDLE);
    assign done  = (state == ST_DONE);

    // illegal requests return zero
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            rd <= dec.illegal ? '0 : rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            illegal <= 1'b0;
        end else if (dec.valid) begin
            illegal <= dec.illegal;
        end
    end

    // no request is taken while a result waits for writeback
    a_no_take_while_done: assert property (
        @(posedge clk) disable iff (rst)
        done |-> !dec.valid
    );

    // result held under back-pressure
    a_result_hold: assert property (
        @(posedge clk) disable iff (rst)
        done && !accept |=> $stable(rd) && $stable(illegal)
    );

endmodule

// ==== hdl/csr_unit.sv ====
// CSR unit top level

module csr_unit #(
    parameter csr_pkg::csr_data_t HART_ID   = 32'h0000_0000,
    parameter csr_pkg::csr_data_t RESET_VEC = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               rst,

    // request and writeback handshake
    input  logic               req,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_op_t   op,
    input  csr_pkg::csr_data_t wdata,
    input  logic               accept,
    output logic               ready,
    output logic               done,
    output csr_pkg::csr_data_t rd,
    output logic               illegal,

    // pipeline events
    input  logic               retire,
    input  logic               trap_valid,
    input  priv_pkg::ecode_t   trap_code,
    input  csr_pkg::csr_data_t trap_pc,
    input  logic               mret,

    output priv_pkg::priv_t    priv,
    output csr_pkg::csr_data_t trap_vec,
    output csr_pkg::csr_data_t epc
);

    csr_pkg::csr_data_t                rdata;
    logic [csr_pkg::COUNTER_W-1:0]     cycle;
    logic [csr_pkg::COUNTER_W-1:0]     instret;

    csr_dec_if u_dec_bus ();

    csr_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .ready (ready),
        .addr  (addr),
        .op    (op),
        .wdata (wdata),
        .priv  (priv),
        .dec   (u_dec_bus.decode)
    );

    csr_file #(
        .HART_ID   (HART_ID),
        .RESET_VEC (RESET_VEC)
    ) u_file (
        .clk        (clk),
        .rst        (rst),
        .dec        (u_dec_bus.execute),
        .cycle      (cycle),
        .instret    (instret),
        .trap_valid (trap_valid),
        .trap_code  (trap_code),
        .trap_pc    (trap_pc),
        .mret       (mret),
        .rdata      (rdata),
        .priv       (priv),
        .trap_vec   (trap_vec),
        .epc        (epc)
    );

    csr_counters u_counters (
        .clk     (clk),
        .rst     (rst),
        .retire  (retire),
        .cycle   (cycle),
        .instret (instret)
    );

    csr_result u_result (
        .clk     (clk),
        .rst     (rst),
        .dec     (u_dec_bus.result),
        .rdata   (rdata),
        .accept  (accept),
        .ready   (ready),
        .done    (done),
        .rd      (rd),
        .illegal (illegal)
    );

endmodule

// ==== hdl/priv_pkg.sv ====
// Privilege and trap definitions

package priv_pkg;

    // no supervisor level in this core
    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } priv_t;

    // mstatus field positions
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;

    localparam int ECODE_W = 4;

    typedef logic [ECODE_W-1:0] ecode_t;

    // RV32 base with I, M and U
    localparam logic [31:0] MISA_VALUE = (32'd1 << 30)
                                       | (32'd1 << 20)
                                       | (32'd1 << 12)
                                       | (32'd1 << 8);

endpackage
